//--- cache_pkg.sv
package cache_pkg;

  localparam int TAG_W   = 18;  // upper address bits kept per line
  localparam int INDEX_W = 8;   // 256 sets
  localparam int LINE_W  = 6;   // byte offset inside a 64 byte line
  localparam int CHUNK_W = 128; // one block RAM word, a quarter line
  localparam int WAYS    = 4;
  localparam int WAY_W   = 2;
  localparam int META_W  = 11;  // valid[10:7], dirty[6:3], plru[2:0]
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;

  localparam int SETS       = 1 << INDEX_W;
  localparam int MEM_ADDR_W = TAG_W + INDEX_W + 2; // chunk address toward the backing memory

  typedef enum logic [2:0] {
    ST_IDLE,   // waiting for an AXI request
    ST_LOOKUP, // read request issued to the cache array
    ST_CHECK,  // tag compare result is valid
    ST_EVICT,  // dirty victim goes back to memory
    ST_REFILL, // missing line comes in chunk by chunk
    ST_STORE,  // merged chunk is written on a write hit
    ST_RESP    // rvalid or bvalid held until accepted
  } ctrl_state_t;

endpackage

//--- data_blockram.sv
`timescale 1ns/1ps

module data_blockram import cache_pkg::*; (
  input  logic                          clk,
  input  logic [INDEX_W+1:0]            rd_addr,  // {index, chunk}
  input  logic [INDEX_W+WAY_W+1:0]      wr_addr,  // {index, chunk, way}
  input  logic [CHUNK_W-1:0]            wr_data,
  input  logic                          wr_en,
  output logic [WAYS*CHUNK_W-1:0]       data_out  // way i at [i*CHUNK_W +: CHUNK_W]
);

  logic [WAYS-1:0][CHUNK_W-1:0] mem [0:(SETS*4)-1]; // one row holds the same chunk of all ways

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr[INDEX_W+WAY_W+1:WAY_W]][wr_addr[WAY_W-1:0]] <= wr_data; // only the addressed way changes
    end
    data_out <= mem[rd_addr]; // read returns the old row when both hit the same address
  end

endmodule

//--- tag_blockram.sv
`timescale 1ns/1ps

module tag_blockram import cache_pkg::*; (
  input  logic                      clk,
  input  logic [INDEX_W-1:0]        r_index,
  input  logic [INDEX_W+WAY_W-1:0]  w_index,  // {index, way}
  input  logic [TAG_W-1:0]          tag_in,
  input  logic                      wr_en,
  output logic [WAYS*TAG_W-1:0]     tag_out   // way i at [i*TAG_W +: TAG_W]
);

  logic [WAYS-1:0][TAG_W-1:0] tmem [0:SETS-1]; // all four tags of a set in one row

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tmem[w_index[INDEX_W+WAY_W-1:WAY_W]][w_index[WAY_W-1:0]] <= tag_in; // per way write
    end
    tag_out <= tmem[r_index]; // synchronous read of the whole set
  end

endmodule

//--- metadata_registers.sv
`timescale 1ns/1ps

module metadata_registers import cache_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic [INDEX_W-1:0] rd_addr,
  input  logic [INDEX_W-1:0] wr_addr,
  input  logic [META_W-1:0]  data_in,
  input  logic               wr_en,
  output logic [META_W-1:0]  data_out
);

  logic [META_W-1:0] regs [0:SETS-1]; // valid, dirty and tree bits per set

  assign data_out = regs[rd_addr]; // asynchronous read so the update can be computed in the same cycle

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < SETS; i++) begin
        regs[i] <= '0; // empty cache after reset
      end
    end else if (wr_en) begin
      regs[wr_addr] <= data_in;
    end
  end

endmodule

//--- next_metadata_comb.sv
`timescale 1ns/1ps

module next_metadata_comb import cache_pkg::*; (
  input  logic [WAY_W-1:0]  way,          // way chosen by the tag check
  input  logic [2:0]        plru,
  input  logic [WAYS-1:0]   valid_array,
  input  logic [WAYS-1:0]   dirty_array,
  input  logic              w_tagcheck,   // lookup is accepted as an access
  input  logic              fill_dirty,
  input  logic              hit,
  output logic [META_W-1:0] next_metadata
);

  logic [WAYS-1:0] valid_nxt;
  logic [WAYS-1:0] dirty_nxt;
  logic [2:0]      plru_nxt;

  always_comb begin
    valid_nxt = valid_array;
    dirty_nxt = dirty_array;
    plru_nxt  = plru;
    if (w_tagcheck) begin
      valid_nxt[way] = 1'b1;
      if (hit) begin
        dirty_nxt[way] = dirty_array[way] | fill_dirty; // a store hit only ever adds dirt
      end else begin
        dirty_nxt[way] = fill_dirty; // the refilled line starts with the requester's dirty value
      end
      plru_nxt[2] = ~way[1]; // root points at the half that was not used
      if (way[1]) begin
        plru_nxt[0] = ~way[0]; // right subtree points at the sibling way
      end else begin
        plru_nxt[1] = ~way[0]; // left subtree points at the sibling way
      end
    end
  end

  assign next_metadata = {valid_nxt, dirty_nxt, plru_nxt};

endmodule

//--- data_cache.sv
`timescale 1ns/1ps

module data_cache import cache_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               r,
  input  logic [INDEX_W-1:0] r_index,
  input  logic [TAG_W-1:0]   r_tag,
  input  logic [LINE_W-1:0]  r_line,       // only bits 5:4 pick the chunk
  input  logic               w,
  input  logic [INDEX_W-1:0] w_index,
  input  logic [TAG_W-1:0]   w_tag,
  input  logic [LINE_W-1:0]  w_line,
  input  logic [WAY_W-1:0]   w_way,
  input  logic [CHUNK_W-1:0] w_data,
  input  logic               w_tagcheck,
  input  logic               fill_dirty,   // sampled in the cycle after the lookup
  output logic               hit,
  output logic [WAY_W-1:0]   way,
  output logic               dirty,
  output logic [TAG_W-1:0]   tag_out,
  output logic [CHUNK_W-1:0] data_out,
  output logic [WAYS-1:0]    dirty_array
);

  logic [INDEX_W+1:0]       rd_addr;
  logic [WAYS*CHUNK_W-1:0]  ram_data;
  logic [WAYS*TAG_W-1:0]    ram_tag;
  logic [META_W-1:0]        meta_ram, meta_in, meta_reg, meta_cur;
  logic                     r_reg, w_tagcheck_reg, fwd_data, fwd_data_reg, fwd_meta_reg;
  logic [INDEX_W-1:0]       r_index_reg;
  logic [TAG_W-1:0]         r_tag_reg, tag_reg;
  logic [CHUNK_W-1:0]       data_reg;
  logic [WAY_W-1:0]         fwd_way_reg, victim_way;
  logic [WAYS-1:0]          valid_array, match;
  logic [2:0]               plru;
  logic [CHUNK_W-1:0]       way_data [WAYS];
  logic [TAG_W-1:0]         way_tag [WAYS];

  assign rd_addr = {r_index, r_line[5:4]};
  assign fwd_data = r & w & (rd_addr == {w_index, w_line[5:4]}); // write lands too late for this read

  data_blockram u_data (.clk(clk), .rd_addr(rd_addr), .wr_addr({w_index, w_line[5:4], w_way}),
                        .wr_data(w_data), .wr_en(w), .data_out(ram_data));

  tag_blockram u_tag (.clk(clk), .r_index(r_index), .w_index({w_index, w_way}), .tag_in(w_tag),
                      .wr_en(w), .tag_out(ram_tag));

  metadata_registers u_meta (.clk(clk), .rst(rst), .rd_addr(r_index), .wr_addr(r_index_reg),
                             .data_in(meta_in), .wr_en(r_reg & w_tagcheck_reg), .data_out(meta_ram));

  next_metadata_comb u_next (.way(way), .plru(plru), .valid_array(valid_array),
                             .dirty_array(dirty_array), .w_tagcheck(w_tagcheck_reg),
                             .fill_dirty(fill_dirty), .hit(hit), .next_metadata(meta_in));

  assign meta_cur    = fwd_meta_reg ? meta_reg : meta_ram; // same set read right after its update
  assign valid_array = meta_cur[10:7];
  assign dirty_array = meta_cur[6:3];
  assign plru        = meta_cur[2:0];

  // unpack ways and patch in a write that collided with the read
  always_comb begin
    for (int i = 0; i < WAYS; i++) begin
      way_data[i] = ram_data[i*CHUNK_W +: CHUNK_W];
      way_tag[i]  = ram_tag[i*TAG_W +: TAG_W];
      if (fwd_data_reg && fwd_way_reg == WAY_W'(i)) begin
        way_data[i] = data_reg;
        way_tag[i]  = tag_reg;
      end
      match[i] = valid_array[i] & (way_tag[i] == r_tag_reg);
    end
  end

  // invalid ways are filled first, lowest number wins, then the tree decides
  always_comb begin
    if (!valid_array[0])      victim_way = 2'd0;
    else if (!valid_array[1]) victim_way = 2'd1;
    else if (!valid_array[2]) victim_way = 2'd2;
    else if (!valid_array[3]) victim_way = 2'd3;
    else if (plru[2])         victim_way = {1'b1, plru[0]};
    else                      victim_way = {1'b0, plru[1]};
  end

  assign hit      = |match;
  assign way      = hit ? {match[3] | match[2], match[3] | match[1]} : victim_way;
  assign dirty    = dirty_array[way];
  assign tag_out  = way_tag[way];
  assign data_out = way_data[way];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      r_reg          <= 1'b0;
      w_tagcheck_reg <= 1'b0;
      fwd_data_reg   <= 1'b0;
      fwd_meta_reg   <= 1'b0;
    end else begin
      r_reg          <= r;
      w_tagcheck_reg <= w_tagcheck & r;
      fwd_data_reg   <= fwd_data;
      fwd_meta_reg   <= r & r_reg & w_tagcheck_reg & (r_index == r_index_reg); // update lands this edge
    end
  end

  always_ff @(posedge clk) begin
    r_index_reg <= r_index;
    r_tag_reg   <= r_tag;
    tag_reg     <= w_tag;
    data_reg    <= w_data;
    fwd_way_reg <= w_way;
    meta_reg    <= meta_in;
  end

endmodule

//--- cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [ADDR_W-1:0]     awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [DATA_W-1:0]     wdata,
  input  logic [DATA_W/8-1:0]   wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [ADDR_W-1:0]     araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [DATA_W-1:0]     rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  output logic                  r,
  output logic [INDEX_W-1:0]    r_index,
  output logic [TAG_W-1:0]      r_tag,
  output logic [LINE_W-1:0]     r_line,
  output logic                  w,
  output logic [INDEX_W-1:0]    w_index,
  output logic [TAG_W-1:0]      w_tag,
  output logic [LINE_W-1:0]     w_line,
  output logic [WAY_W-1:0]      w_way,
  output logic [CHUNK_W-1:0]    w_data,
  output logic                  w_tagcheck,
  output logic                  fill_dirty,
  input  logic                  hit,
  input  logic [WAY_W-1:0]      way,
  input  logic                  dirty,
  input  logic [TAG_W-1:0]      tag_out,
  input  logic [CHUNK_W-1:0]    data_out,
  output logic                  mem_we,
  output logic                  mem_re,
  output logic [MEM_ADDR_W-1:0] mem_addr,
  output logic [CHUNK_W-1:0]    mem_wdata,
  input  logic [CHUNK_W-1:0]    mem_rdata,
  input  logic                  mem_rvalid
);

  ctrl_state_t         state;
  logic                accept_en, req_write, pending;
  logic [ADDR_W-1:0]   req_addr;
  logic [DATA_W-1:0]   req_wdata, rdata_q;
  logic [DATA_W/8-1:0] req_strb;
  logic [WAY_W-1:0]    sel_way;             // hit way, or victim way after a miss
  logic [TAG_W-1:0]    victim_tag;
  logic [2:0]          cnt;                 // chunk counter for write-back and refill
  logic [1:0]          wb_chunk;
  logic [CHUNK_W-1:0]  chunk_q, store_chunk;

  assign arready = accept_en & (state == ST_IDLE);
  assign awready = accept_en & (state == ST_IDLE) & awvalid & wvalid & ~arvalid; // reads go first
  assign wready  = awready;
  assign rvalid  = (state == ST_RESP) & ~req_write;
  assign bvalid  = (state == ST_RESP) & req_write;
  assign rdata   = rdata_q;
  assign rresp   = 2'b00;
  assign bresp   = 2'b00;

  assign wb_chunk   = cnt[1:0] - 2'd1; // write-back trails the array read by one cycle
  assign r          = (state == ST_LOOKUP) | ((state == ST_EVICT) & ~cnt[2]);
  assign r_index    = req_addr[13:6];
  assign r_tag      = (state == ST_EVICT) ? victim_tag : req_addr[31:14]; // victim read hits its own way
  assign r_line     = (state == ST_EVICT) ? {cnt[1:0], 4'b0} : req_addr[5:0];
  assign w_tagcheck = (state == ST_LOOKUP);
  assign fill_dirty = req_write;
  assign w          = (state == ST_STORE) | ((state == ST_REFILL) & mem_rvalid);
  assign w_index    = req_addr[13:6];
  assign w_tag      = req_addr[31:14];
  assign w_line     = (state == ST_REFILL) ? {cnt[1:0], 4'b0} : req_addr[5:0];
  assign w_way      = sel_way;
  assign w_data     = (state == ST_REFILL) ? mem_rdata : store_chunk;
  assign mem_we     = (state == ST_EVICT) & (cnt != 3'd0);
  assign mem_re     = (state == ST_REFILL) & ~pending;
  assign mem_addr   = (state == ST_EVICT) ? {victim_tag, req_addr[13:6], wb_chunk}
                                          : {req_addr[31:14], req_addr[13:6], cnt[1:0]};
  assign mem_wdata  = data_out;

  // byte strobes merged into the word picked by address bits 3:2
  always_comb begin
    store_chunk = chunk_q;
    for (int b = 0; b < DATA_W/8; b++) begin
      if (req_strb[b]) store_chunk[req_addr[3:2]*DATA_W + b*8 +: 8] = req_wdata[b*8 +: 8];
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state     <= ST_IDLE;
      accept_en <= 1'b0;
      cnt       <= '0;
      pending   <= 1'b0;
    end else begin
      accept_en <= 1'b1; // first request is taken one cycle after reset
      case (state)
        ST_IDLE:   if (arready && arvalid) state <= ST_LOOKUP;
                   else if (awready) state <= ST_LOOKUP;
        ST_LOOKUP: state <= ST_CHECK;
        ST_CHECK: begin
          cnt     <= '0;
          pending <= 1'b0;
          if (hit) state <= req_write ? ST_STORE : ST_RESP;
          else     state <= dirty ? ST_EVICT : ST_REFILL;
        end
        ST_EVICT: begin
          cnt <= cnt + 3'd1;
          if (cnt == 3'd4) begin
            cnt   <= '0;
            state <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          if (mem_re) pending <= 1'b1;
          if (mem_rvalid) begin
            pending <= 1'b0;
            cnt     <= cnt + 3'd1;
            if (cnt == 3'd3) state <= ST_LOOKUP; // repeat the lookup, it hits now
          end
        end
        ST_STORE:  state <= ST_RESP;
        ST_RESP:   if ((rvalid && rready) || (bvalid && bready)) state <= ST_IDLE;
        default:   state <= ST_IDLE;
      endcase
    end
  end

  // request and result payload
  always_ff @(posedge clk) begin
    if (state == ST_IDLE) begin
      if (arready && arvalid) begin
        req_addr  <= araddr;
        req_write <= 1'b0;
      end else if (awready) begin
        req_addr  <= awaddr;
        req_wdata <= wdata;
        req_strb  <= wstrb;
        req_write <= 1'b1;
      end
    end
    if (state == ST_CHECK) begin
      sel_way    <= way;
      victim_tag <= tag_out;
      chunk_q    <= data_out;
      rdata_q    <= data_out[req_addr[3:2]*DATA_W +: DATA_W];
    end
  end

endmodule

//--- line_memory.sv
`timescale 1ns/1ps

module line_memory import cache_pkg::*; #(
  parameter int MEM_CHUNKS  = 4096, // power of two so the address simply wraps
  parameter int MEM_LATENCY = 3
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mem_we,
  input  logic                  mem_re,
  input  logic [MEM_ADDR_W-1:0] mem_addr,
  input  logic [CHUNK_W-1:0]    mem_wdata,
  output logic [CHUNK_W-1:0]    mem_rdata,
  output logic                  mem_rvalid
);

  localparam int AW = $clog2(MEM_CHUNKS);

  logic [CHUNK_W-1:0]     mem [0:MEM_CHUNKS-1];
  logic [CHUNK_W-1:0]     data_pipe [MEM_LATENCY];
  logic [MEM_LATENCY-1:0] valid_pipe; // one bit per cycle of delay

  initial begin
    for (int i = 0; i < MEM_CHUNKS; i++) mem[i] = '0; // memory starts out all zero
  end

  always_ff @(posedge clk) begin
    if (mem_we) mem[mem_addr[AW-1:0]] <= mem_wdata;
    data_pipe[0] <= mem[mem_addr[AW-1:0]];
    for (int i = 1; i < MEM_LATENCY; i++) data_pipe[i] <= data_pipe[i-1];
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) valid_pipe <= '0;
    else     valid_pipe <= {valid_pipe[MEM_LATENCY-2:0], mem_re};
  end

  assign mem_rdata  = data_pipe[MEM_LATENCY-1];
  assign mem_rvalid = valid_pipe[MEM_LATENCY-1]; // pulses MEM_LATENCY cycles after mem_re

endmodule

//--- cache_top.sv
`timescale 1ns/1ps

module cache_top import cache_pkg::*; #(
  parameter int MEM_CHUNKS  = 4096,
  parameter int MEM_LATENCY = 3
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [ADDR_W-1:0]   awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [DATA_W-1:0]   wdata,
  input  logic [DATA_W/8-1:0] wstrb,
  input  logic                wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic [ADDR_W-1:0]   araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [DATA_W-1:0]   rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready
);

  logic                  r, w, w_tagcheck, fill_dirty, hit, dirty;
  logic [INDEX_W-1:0]    r_index, w_index;
  logic [TAG_W-1:0]      r_tag, w_tag, tag_out;
  logic [LINE_W-1:0]     r_line, w_line;
  logic [WAY_W-1:0]      w_way, way;
  logic [CHUNK_W-1:0]    w_data, data_out, mem_wdata, mem_rdata;
  logic                  mem_we, mem_re, mem_rvalid;
  logic [MEM_ADDR_W-1:0] mem_addr;

  cache_ctrl u_ctrl (.*); // AXI front end and sequencing

  data_cache u_cache (.clk(clk), .rst(rst), .r(r), .r_index(r_index), .r_tag(r_tag),
                      .r_line(r_line), .w(w), .w_index(w_index), .w_tag(w_tag), .w_line(w_line),
                      .w_way(w_way), .w_data(w_data), .w_tagcheck(w_tagcheck),
                      .fill_dirty(fill_dirty), .hit(hit), .way(way), .dirty(dirty),
                      .tag_out(tag_out), .data_out(data_out), .dirty_array());

  line_memory #(.MEM_CHUNKS(MEM_CHUNKS), .MEM_LATENCY(MEM_LATENCY)) u_mem (
    .clk(clk), .rst(rst), .mem_we(mem_we), .mem_re(mem_re), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid)
  );

endmodule

//--- tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top import cache_pkg::*; ();

  localparam int PERIOD     = 20;
  localparam int QUARTER    = PERIOD / 4;  // outputs are sampled this long after the falling edge
  localparam int MEM_CHUNKS = 16384;       // 256 KB, so eight tags of one set never alias
  localparam int REF_WORDS  = MEM_CHUNKS * 4;
  localparam int TIMEOUT    = 400;         // cycles, well above a dirty miss with refill

  typedef enum logic {OP_READ, OP_WRITE} op_t;

  typedef struct packed {
    op_t                 op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] strb;
    logic [DATA_W-1:0]   exp;   // expected read data, unused for writes
  } step_t;

  logic                clk, rst;
  logic [ADDR_W-1:0]   awaddr, araddr;
  logic                awvalid, awready, wvalid, wready, bvalid, bready;
  logic [DATA_W-1:0]   wdata, rdata;
  logic [DATA_W/8-1:0] wstrb;
  logic [1:0]          bresp, rresp;
  logic                arvalid, arready, rvalid, rready;

  step_t             steps [$];                // directed table, applied in order
  logic [DATA_W-1:0] ref_mem [0:REF_WORDS-1];  // word image of the whole backing memory
  int                stall_max;                // longest response back-pressure in cycles

  cache_top #(.MEM_CHUNKS(MEM_CHUNKS), .MEM_LATENCY(3)) DUT (.*);

  always #(PERIOD/2) clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] actual,
                            input logic [DATA_W-1:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] actual,
                            input logic [1:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual));
    end
  endtask

  function automatic int ref_index(input logic [ADDR_W-1:0] addr);
    return int'(addr[ADDR_W-1:2]) % REF_WORDS;  // same wrap as the chunk memory
  endfunction

  task automatic ref_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [DATA_W/8-1:0] strb);
    int i;
    i = ref_index(addr);
    for (int b = 0; b < DATA_W/8; b++) begin
      if (strb[b]) ref_mem[i][b*8 +: 8] = data[b*8 +: 8];  // only strobed bytes change
    end
  endtask

  task automatic add_step(input op_t op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic [DATA_W/8-1:0] strb,
                          input logic [DATA_W-1:0] exp);
    step_t s;
    s.op   = op;
    s.addr = addr;
    s.data = data;
    s.strb = strb;
    s.exp  = exp;
    steps.push_back(s);
  endtask

  task automatic drive_ready(input op_t op, input logic level);
    if (op == OP_WRITE) bready = level;
    else                rready = level;
  endtask

  // returns at the falling edge after the address handshake
  task automatic wait_request_accept(input op_t op);
    int n;
    n = 0;
    #(QUARTER);
    while ((op == OP_WRITE) ? !(awready && wready) : !arready) begin
      n++;
      if (n > TIMEOUT) begin
        if (op == OP_WRITE) fail_run("write address and data were never accepted");
        else                fail_run("read address was never accepted");
      end
      @(negedge clk);
      #(QUARTER);
    end
    @(negedge clk);  // the accepting rising edge is behind us now
  endtask

  task automatic collect_response(input op_t op, output logic [DATA_W-1:0] data,
                                  output logic [1:0] resp);
    int                n;
    int                hold;
    logic              seen, done, valid_now;
    logic [DATA_W-1:0] held;
    n    = 0;
    hold = (stall_max > 0) ? int'($urandom_range(stall_max, 0)) : 0;
    seen = 1'b0;
    done = 1'b0;
    held = '0;
    data = '0;
    resp = '0;
    drive_ready(op, hold == 0);  // ready may lead valid when there is no stall
    while (!done) begin
      #(QUARTER);
      valid_now = (op == OP_WRITE) ? bvalid : rvalid;
      if (valid_now) begin
        if (seen && op == OP_READ) check_data("rdata while stalled", rdata, held);
        if (arready) fail_run("a new request was accepted while a response was pending");
        seen = 1'b1;
        held = rdata;
        data = (op == OP_WRITE) ? '0 : rdata;
        resp = (op == OP_WRITE) ? bresp : rresp;
        done = (op == OP_WRITE) ? bready : rready;
      end else if (seen) begin
        fail_run("response valid dropped before it was accepted");
      end
      n++;
      if (n > TIMEOUT) fail_run("response handshake never completed");
      @(negedge clk);
      if (seen && hold > 0) hold--;  // the stall only counts once the response is up
      drive_ready(op, hold == 0 && !done);
    end
  endtask

  task automatic apply_step(input step_t s);
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    if (s.op == OP_WRITE) begin
      awaddr  = s.addr;
      wdata   = s.data;
      wstrb   = s.strb;
      awvalid = 1'b1;
      wvalid  = 1'b1;
    end else begin
      araddr  = s.addr;
      arvalid = 1'b1;
    end
    wait_request_accept(s.op);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    collect_response(s.op, data, resp);
    if (s.op == OP_WRITE) begin
      check_resp("bresp", resp, 2'b00);
      ref_write(s.addr, s.data, s.strb);
    end else begin
      check_resp("rresp", resp, 2'b00);
      check_data($sformatf("rdata at %h", s.addr), data, s.exp);
    end
  endtask

  // eight tags times two sets, so evictions and refills happen all the time
  task automatic run_random_ops(input int count);
    step_t      s;
    logic [2:0] tag;
    logic [7:0] index;
    logic [3:0] word;
    for (int k = 0; k < count; k++) begin
      tag    = 3'($urandom_range(7, 0));
      index  = ($urandom_range(1, 0) == 1) ? 8'd5 : 8'd6;
      word   = 4'($urandom_range(15, 0));
      s.op   = ($urandom_range(1, 0) == 1) ? OP_WRITE : OP_READ;
      s.addr = {15'd0, tag, index, word, 2'b00};
      s.data = $urandom();
      s.strb = 4'($urandom_range(15, 1));
      s.exp  = ref_mem[ref_index(s.addr)];
      apply_step(s);
    end
  endtask

  task automatic build_table();
    add_step(OP_READ,  32'h0000_0100, 32'h0, 4'h0, 32'h0000_0000); // miss on an empty cache
    add_step(OP_READ,  32'h0000_0104, 32'h0, 4'h0, 32'h0000_0000); // hit in the same line
    add_step(OP_READ,  32'h0002_3ffc, 32'h0, 4'h0, 32'h0000_0000);
    add_step(OP_WRITE, 32'h0000_0100, 32'h1122_3344, 4'hf, 32'h0);
    add_step(OP_READ,  32'h0000_0100, 32'h0, 4'h0, 32'h1122_3344);
    add_step(OP_WRITE, 32'h0000_0100, 32'haabb_ccdd, 4'h5, 32'h0);  // bytes 0 and 2 only
    add_step(OP_READ,  32'h0000_0100, 32'h0, 4'h0, 32'h11bb_33dd);
    add_step(OP_WRITE, 32'h0000_0108, 32'hcafe_f00d, 4'h8, 32'h0);  // top byte only
    add_step(OP_READ,  32'h0000_0108, 32'h0, 4'h0, 32'hca00_0000);
    add_step(OP_READ,  32'h0000_0104, 32'h0, 4'h0, 32'h0000_0000);
    add_step(OP_WRITE, 32'h0000_0140, 32'h5000_0000, 4'hf, 32'h0);  // set 5, five tags
    add_step(OP_WRITE, 32'h0000_4144, 32'h5000_0001, 4'hf, 32'h0);
    add_step(OP_WRITE, 32'h0000_8148, 32'h5000_0002, 4'hf, 32'h0);
    add_step(OP_WRITE, 32'h0000_c14c, 32'h5000_0003, 4'hf, 32'h0);
    add_step(OP_WRITE, 32'h0001_0140, 32'h5000_0004, 4'hf, 32'h0);  // evicts a dirty line
    add_step(OP_READ,  32'h0000_0140, 32'h0, 4'h0, 32'h5000_0000);
    add_step(OP_READ,  32'h0000_4144, 32'h0, 4'h0, 32'h5000_0001);
    add_step(OP_READ,  32'h0000_8148, 32'h0, 4'h0, 32'h5000_0002);
    add_step(OP_READ,  32'h0000_c14c, 32'h0, 4'h0, 32'h5000_0003);
    add_step(OP_READ,  32'h0001_0140, 32'h0, 4'h0, 32'h5000_0004);
    add_step(OP_READ,  32'h0000_0144, 32'h0, 4'h0, 32'h0000_0000);
    add_step(OP_WRITE, 32'h0000_0240, 32'h6111_1111, 4'hf, 32'h0);  // sets 9 and 65 alternate
    add_step(OP_READ,  32'h0000_0244, 32'h0, 4'h0, 32'h0000_0000);  // same chunk right after
    add_step(OP_READ,  32'h0000_0240, 32'h0, 4'h0, 32'h6111_1111);
    add_step(OP_WRITE, 32'h0000_1040, 32'h6222_2222, 4'hf, 32'h0);
    add_step(OP_READ,  32'h0000_1040, 32'h0, 4'h0, 32'h6222_2222);
    add_step(OP_WRITE, 32'h0000_0240, 32'h0000_ab00, 4'h2, 32'h0);
    add_step(OP_READ,  32'h0000_0240, 32'h0, 4'h0, 32'h6111_ab11);
    add_step(OP_READ,  32'h0000_1000, 32'h0, 4'h0, 32'h0000_0000);
  endtask

  initial begin
    void'($urandom(32'ha5a3590e));  // one seed for the whole run
    clk       = 1'b0;
    rst       = 1'b1;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    stall_max = 0;
    for (int i = 0; i < REF_WORDS; i++) ref_mem[i] = '0;  // backing memory starts at zero
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (steps[i]) apply_step(steps[i]);
    stall_max = 6;
    run_random_ops(40);   // long ready stalls on rready and bready
    stall_max = 2;
    run_random_ops(300);
    $display("Regression passed");
    $finish;
  end

endmodule

//--- compile.f
cache_pkg.sv
data_blockram.sv
tag_blockram.sv
metadata_registers.sv
next_metadata_comb.sv
data_cache.sv
cache_ctrl.sv
line_memory.sv
cache_top.sv
tb_cache_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal --top-module tb_cache_top -f compile.f \
  -o sim_cache > build.log 2>&1 \
  && ./obj_dir/sim_cache > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation returned an error" >> sim.log; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
